// File: Bender.yml
package:
  name: lsu_iq

sources:
  - design/lsu_iq_pkg.sv
  - design/lsu_iq_ctrl.sv
  - design/iq_entry.sv
  - design/lsu_agu.sv
  - design/lsu_dmem.sv
  - design/lsu_iq_top.sv
  - target: simulation
    files:
      - dv/lsu_iq_properties.sv
      - dv/lsu_iq_tb.sv

// File: design/iq_entry.sv
`timescale 1ns/1ps

module iq_entry
    import lsu_iq_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n_i,
    input  logic          flush_i,
    input  logic          init_i,
    input  logic          issue_i,
    input  lsu_op_e       op_i,
    input  imm_t          imm_i,
    input  rob_id_t       dst_i,
    input  rob_id_t [1:0] src_tag_i,
    input  logic    [1:0] src_rdy_i,
    input  word_t   [1:0] src_data_i,
    input  logic          cdb_valid_i,
    input  rob_id_t       cdb_tag_i,
    input  word_t         cdb_data_i,
    output logic          ready_o,
    output lsu_op_e       op_o,
    output imm_t          imm_o,
    output rob_id_t       dst_o,
    output word_t   [1:0] data_o
);

    logic          occ_q;
    logic    [1:0] src_vld_q;
    rob_id_t [1:0] src_tag_q;
    word_t   [1:0] src_data_q;
    lsu_op_e       op_q;
    imm_t          imm_q;
    rob_id_t       dst_q;
    logic    [1:0] wake;
    logic    [1:0] hit_in;

    // waiting operands snoop the CDB
    // incoming operands can catch a broadcast in the dispatch cycle
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            wake[k]   = occ_q && !src_vld_q[k] && cdb_valid_i && (cdb_tag_i == src_tag_q[k]);
            hit_in[k] = !src_rdy_i[k] && cdb_valid_i && (cdb_tag_i == src_tag_i[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            occ_q     <= 1'b0;
            src_vld_q <= '0;
        end else if (init_i) begin
            occ_q     <= 1'b1;
            src_vld_q <= src_rdy_i | hit_in;
        end else begin
            if (issue_i) begin
                occ_q <= 1'b0;
            end
            src_vld_q <= src_vld_q | wake;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (init_i) begin
            op_q      <= op_i;
            imm_q     <= imm_i;
            dst_q     <= dst_i;
            src_tag_q <= src_tag_i;
            for (int k = 0; k < 2; k++) begin
                src_data_q[k] <= hit_in[k] ? cdb_data_i : src_data_i[k];
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (wake[k]) begin
                    src_data_q[k] <= cdb_data_i;
                end
            end
        end
    end

    assign ready_o = occ_q && (&src_vld_q);
    assign op_o    = op_q;
    assign imm_o   = imm_q;
    assign dst_o   = dst_q;
    assign data_o  = src_data_q;

endmodule

// File: design/lsu_agu.sv
`timescale 1ns/1ps

module lsu_agu
    import lsu_iq_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    flush_i,
    input  logic    issue_i,
    input  lsu_op_e op_i,
    input  imm_t    imm_i,
    input  rob_id_t dst_i,
    input  word_t   base_i,
    input  word_t   wdata_i,
    output logic    ready_o,
    output logic    req_valid_o,
    input  logic    req_ready_i,
    output lsu_op_e req_op_o,
    output word_t   req_addr_o,
    output word_t   req_wdata_o,
    output rob_id_t req_tag_o
);

    logic  valid_q;
    word_t addr;

    // byte address from base and sign-extended offset
    assign addr = base_i + {{(DATA_W-IMM_W){imm_i[IMM_W-1]}}, imm_i};

    // slot frees up when empty or drained this cycle
    assign ready_o     = !valid_q || req_ready_i;
    assign req_valid_o = valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= issue_i;
        end
    end

    // request payload, held until the scratchpad takes it
    always_ff @(posedge clk) begin
        if (issue_i && ready_o) begin
            req_op_o    <= op_i;
            req_addr_o  <= addr;
            req_wdata_o <= wdata_i;
            req_tag_o   <= dst_i;
        end
    end

endmodule

// File: design/lsu_dmem.sv
`timescale 1ns/1ps

module lsu_dmem
    import lsu_iq_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    flush_i,
    input  logic    req_valid_i,
    output logic    req_ready_o,
    input  lsu_op_e req_op_i,
    input  word_t   req_addr_i,
    input  word_t   req_wdata_i,
    input  rob_id_t req_tag_i,
    output logic    res_valid_o,
    input  logic    res_ready_i,
    output rob_id_t res_tag_o,
    output word_t   res_data_o
);

    word_t             mem [MEM_WORDS];
    logic [MEM_AW-1:0] idx;
    logic [1:0]        lane;
    logic              accept;
    word_t             rd_word;
    logic [7:0]        rd_byte;
    word_t             load_data;

    assign idx         = req_addr_i[MEM_AW+1:2];
    assign lane        = req_addr_i[1:0];
    assign req_ready_o = !res_valid_o || res_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    // ----------------------------------------
    // array access
    // ----------------------------------------
    // a store caught by flush is dropped
    always_ff @(posedge clk) begin
        if (accept && !flush_i) begin
            if (req_op_i == ST_W) begin
                mem[idx] <= req_wdata_i;
            end else if (req_op_i == ST_B) begin
                mem[idx][{lane, 3'b000} +: 8] <= req_wdata_i[7:0];
            end
        end
    end

    assign rd_word = mem[idx];
    assign rd_byte = rd_word[{lane, 3'b000} +: 8];

    always_comb begin
        case (req_op_i)
            LD_B:    load_data = {{(DATA_W-8){rd_byte[7]}}, rd_byte};
            LD_BU:   load_data = {{(DATA_W-8){1'b0}}, rd_byte};
            default: load_data = rd_word;
        endcase
    end

    // ----------------------------------------
    // one-deep response register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            res_valid_o <= 1'b0;
        end else if (req_ready_o) begin
            res_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_tag_o  <= req_tag_i;
            res_data_o <= is_store(req_op_i) ? '0 : load_data;
        end
    end

endmodule

// File: design/lsu_iq_ctrl.sv
`timescale 1ns/1ps

module lsu_iq_ctrl
    import lsu_iq_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  logic [1:0]         disp_valid_i,
    input  logic               head_rdy_i,
    input  logic               agu_ready_i,
    output logic [IQ_SIZE-1:0] entry_init_o,
    output logic               issue_o,
    output logic [PTR_LEN-1:0] head_o,
    output logic               disp_ready_o
);

    logic [PTR_LEN-1:0] head_q;
    logic [PTR_LEN-1:0] head_d;
    logic [PTR_LEN-1:0] tail_q;
    logic [PTR_LEN-1:0] tail_d;
    logic [PTR_LEN-1:0] tail_nx;
    logic [CNT_LEN-1:0] free_q;
    logic [CNT_LEN-1:0] free_d;
    logic [1:0]         accept;
    logic [CNT_LEN-1:0] n_accept;

    // ----------------------------------------
    // dispatch and issue decisions
    // ----------------------------------------
    assign accept   = disp_valid_i & {2{disp_ready_o}};
    assign n_accept = CNT_LEN'(accept[0]) + CNT_LEN'(accept[1]);

    // in-order issue, head only
    assign issue_o = head_rdy_i & agu_ready_i;
    assign head_o  = head_q;
    assign tail_nx = tail_q + PTR_LEN'(1);

    always_comb begin
        head_d = head_q + PTR_LEN'(issue_o);
        tail_d = tail_q + n_accept[PTR_LEN-1:0];
        free_d = free_q - n_accept + CNT_LEN'(issue_o);
    end

    // slot 0 lands at tail, slot 1 right after it
    always_comb begin
        entry_init_o = '0;
        if (accept[0]) begin
            entry_init_o[tail_q] = 1'b1;
        end
        if (accept[1]) begin
            entry_init_o[tail_nx] = 1'b1;
        end
    end

    // ----------------------------------------
    // pointer state
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            head_q       <= '0;
            tail_q       <= '0;
            free_q       <= CNT_LEN'(IQ_SIZE);
            disp_ready_o <= 1'b1;
        end else begin
            head_q       <= head_d;
            tail_q       <= tail_d;
            free_q       <= free_d;
            // room for a full two-wide dispatch next cycle
            disp_ready_o <= (free_d >= CNT_LEN'(2));
        end
    end

endmodule

// File: design/lsu_iq_pkg.sv
package lsu_iq_pkg;

    // ----------------------------------------
    // queue geometry
    // ----------------------------------------
    localparam int IQ_SIZE = 8;
    localparam int PTR_LEN = $clog2(IQ_SIZE);
    // free count needs one extra bit to hold IQ_SIZE itself
    localparam int CNT_LEN = PTR_LEN + 1;

    // ----------------------------------------
    // scratchpad geometry
    // ----------------------------------------
    localparam int MEM_WORDS = 64;
    localparam int MEM_AW    = 6;

    // datapath widths
    localparam int DATA_W = 32;
    localparam int TAG_W  = 6;
    localparam int IMM_W  = 12;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [TAG_W-1:0]  rob_id_t;
    typedef logic [IMM_W-1:0]  imm_t;

    // operand slots of every memory op
    // slot 0 is the store data, slot 1 the base address
    localparam int OPND_DATA = 0;
    localparam int OPND_BASE = 1;

    typedef enum logic [2:0] {
        LD_W  = 3'd0,
        LD_B  = 3'd1,
        LD_BU = 3'd2,
        ST_W  = 3'd3,
        ST_B  = 3'd4
    } lsu_op_e;

    // stores answer with zero data
    function automatic logic is_store(lsu_op_e op);
        return (op == ST_W) || (op == ST_B);
    endfunction

endpackage

// File: design/lsu_iq_top.sv
`timescale 1ns/1ps

module lsu_iq_top
    import lsu_iq_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    // dispatch, index is the slot
    input  logic    [1:0]      disp_valid_i,
    input  lsu_op_e [1:0]      disp_op_i,
    input  imm_t    [1:0]      disp_imm_i,
    input  rob_id_t [1:0]      disp_dst_i,
    input  rob_id_t [1:0][1:0] disp_src_tag_i,
    input  logic    [1:0][1:0] disp_src_rdy_i,
    input  word_t   [1:0][1:0] disp_src_data_i,
    output logic               disp_ready_o,
    // result broadcast
    input  logic               cdb_valid_i,
    input  rob_id_t            cdb_tag_i,
    input  word_t              cdb_data_i,
    // completion
    output logic               res_valid_o,
    input  logic               res_ready_i,
    output rob_id_t            res_tag_o,
    output word_t              res_data_o
);

    logic    [IQ_SIZE-1:0]      entry_init;
    logic    [IQ_SIZE-1:0]      entry_slot1;
    logic    [IQ_SIZE-1:0]      entry_rdy;
    lsu_op_e [IQ_SIZE-1:0]      entry_op;
    imm_t    [IQ_SIZE-1:0]      entry_imm;
    rob_id_t [IQ_SIZE-1:0]      entry_dst;
    word_t   [IQ_SIZE-1:0][1:0] entry_data;
    logic    [PTR_LEN-1:0]      head;
    logic                       issue;
    logic                       agu_ready;
    logic                       req_valid;
    logic                       req_ready;
    lsu_op_e                    req_op;
    word_t                      req_addr;
    word_t                      req_wdata;
    rob_id_t                    req_tag;

    lsu_iq_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .disp_valid_i (disp_valid_i),
        .head_rdy_i   (entry_rdy[head]),
        .agu_ready_i  (agu_ready),
        .entry_init_o (entry_init),
        .issue_o      (issue),
        .head_o       (head),
        .disp_ready_o (disp_ready_o)
    );

    // ----------------------------------------
    // queue entries
    // ----------------------------------------
    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        // second of two adjacent init bits takes slot 1
        assign entry_slot1[i] = entry_init[i] && entry_init[(i + IQ_SIZE - 1) % IQ_SIZE];

        iq_entry u_entry (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .init_i      (entry_init[i]),
            .issue_i     (issue && (head == PTR_LEN'(i))),
            .op_i        (disp_op_i[entry_slot1[i]]),
            .imm_i       (disp_imm_i[entry_slot1[i]]),
            .dst_i       (disp_dst_i[entry_slot1[i]]),
            .src_tag_i   (disp_src_tag_i[entry_slot1[i]]),
            .src_rdy_i   (disp_src_rdy_i[entry_slot1[i]]),
            .src_data_i  (disp_src_data_i[entry_slot1[i]]),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .cdb_data_i  (cdb_data_i),
            .ready_o     (entry_rdy[i]),
            .op_o        (entry_op[i]),
            .imm_o       (entry_imm[i]),
            .dst_o       (entry_dst[i]),
            .data_o      (entry_data[i])
        );
    end

    // ----------------------------------------
    // address generation and memory
    // ----------------------------------------
    lsu_agu u_agu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .issue_i     (issue),
        .op_i        (entry_op[head]),
        .imm_i       (entry_imm[head]),
        .dst_i       (entry_dst[head]),
        .base_i      (entry_data[head][OPND_BASE]),
        .wdata_i     (entry_data[head][OPND_DATA]),
        .ready_o     (agu_ready),
        .req_valid_o (req_valid),
        .req_ready_i (req_ready),
        .req_op_o    (req_op),
        .req_addr_o  (req_addr),
        .req_wdata_o (req_wdata),
        .req_tag_o   (req_tag)
    );

    lsu_dmem u_dmem (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_op_i    (req_op),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata),
        .req_tag_i   (req_tag),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_tag_o   (res_tag_o),
        .res_data_o  (res_data_o)
    );

endmodule

// File: dv/lsu_iq_properties.sv
`timescale 1ns/1ps

module lsu_iq_properties
    import lsu_iq_pkg::*;
(
    input logic       clk,
    input logic       rst_n_i,
    input logic       flush_i,
    input logic [1:0] disp_valid_i,
    input logic       disp_ready_i,
    input logic       res_valid_i,
    input logic       res_ready_i,
    input rob_id_t    res_tag_i,
    input word_t      res_data_i
);

    // held response must not move until taken
    a_res_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_i && !res_ready_i && !flush_i |=>
            res_valid_i && $stable(res_tag_i) && $stable(res_data_i))
        else $error("held result changed before it was accepted");

    // pipeline is empty right after reset or flush
    a_quiet_after_clear: assert property (@(posedge clk)
        (!rst_n_i || flush_i) |=> !res_valid_i ##1 !res_valid_i)
        else $error("result appeared right after reset or flush");

    a_disp_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
        (|disp_valid_i) |-> disp_ready_i)
        else $error("dispatch while queue not ready");

endmodule

bind lsu_iq_top lsu_iq_properties u_props (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .disp_valid_i (disp_valid_i),
    .disp_ready_i (disp_ready_o),
    .res_valid_i  (res_valid_o),
    .res_ready_i  (res_ready_i),
    .res_tag_i    (res_tag_o),
    .res_data_i   (res_data_o)
);

// File: dv/lsu_iq_stimulus.txt
// four words per record: w0 = cmd[31:28] op[27:24] imm[23:12] tag[11:4] rdy[3:0]
// w1 = data tag[15:8] base tag[7:0], w2 = store data or value, w3 = base address
// cmd: 0 section, 1 dispatch, 2 pair with next record, 3 cdb, 4 cdb with next dispatch,
// 5 flush, 6 stall, 7 idle, 8 drain, 9 expect, a check disp_ready, f end
00000000 00000000 00000001 00000000
90000010 00000000 00000000 00000000
90000020 00000000 00000000 00000000
90000030 00000000 11223344 00000000
90000040 00000000 a5a5f00d 00000000
23000013 00000000 11223344 00000040
13004023 00000000 a5a5f00d 00000040
20000033 00000000 00000000 00000040
10ffc043 00000000 00000000 00000048
80000000 00000000 00000000 00000000
// byte stores and extension
00000000 00000000 00000002 00000000
90000050 00000000 00000000 00000000
90000060 00000000 00000000 00000000
90000070 00000000 00000000 00000000
90000080 00000000 7e34f078 00000000
90000090 00000000 fffffff0 00000000
900000a0 00000000 000000f0 00000000
900000c0 00000000 00000034 00000000
23000053 00000000 12345678 00000080
14001063 00000000 000000f0 00000080
14003073 00000000 0000007e 00000080
20000083 00000000 00000000 00000080
11001093 00000000 00000000 00000080
220010a3 00000000 00000000 00000080
120020c3 00000000 00000000 00000080
80000000 00000000 00000000 00000000
// operands woken by cdb, last one in the dispatch cycle
00000000 00000000 00000003 00000000
90000100 00000000 11223344 00000000
90000110 00000000 00000000 00000000
90000120 00000000 deadbeef 00000000
90000130 00000000 7e34f078 00000000
20000101 00000020 00000000 00000000
13000112 00002100 00000000 000000c0
10000123 00000000 00000000 000000c0
30000210 00000000 deadbeef 00000000
30000200 00000000 00000040 00000000
40000220 00000000 00000080 00000000
10000131 00000022 00000000 00000000
80000000 00000000 00000000 00000000
// stalled head fills the queue
00000000 00000000 00000004 00000000
90000180 00000000 a5a5f00d 00000000
90000190 00000000 00000000 00000000
900001a0 00000000 00000000 00000000
900001b0 00000000 00000019 00000000
900001c0 00000000 0000001a 00000000
900001d0 00000000 00000000 00000000
900001e0 00000000 ab000019 00000000
900001f0 00000000 000000ab 00000000
90000200 00000000 ffffffab 00000000
90000210 00000000 a5a5f00d 00000000
20000181 00000023 00000000 00000000
13000193 00000000 00000019 000000d0
230041a3 00000000 0000001a 000000d0
100001b3 00000000 00000000 000000d0
200041c3 00000000 00000000 000000d0
140031d3 00000000 000000ab 000000d0
200001e3 00000000 00000000 000000d0
120031f3 00000000 00000000 000000d0
a0000000 00000000 00000000 00000000
30000230 00000000 00000044 00000000
21003203 00000000 00000000 000000d0
10000213 00000000 00000000 00000044
80000000 00000000 00000000 00000000
a0000000 00000000 00000001 00000000
// random result stalls
00000000 00000000 00000005 00000000
90000280 00000000 11223344 00000000
90000290 00000000 a5a5f00d 00000000
900002a0 00000000 00000000 00000000
900002b0 00000000 0000beef 00000000
900002c0 00000000 000000be 00000000
60000000 00000000 00000004 00000000
20000283 00000000 00000000 00000040
10000293 00000000 00000000 00000044
60000000 00000000 00000004 00000000
230002a3 00000000 0000beef 000000e0
100002b3 00000000 00000000 000000e0
60000000 00000000 00000004 00000000
120012c3 00000000 00000000 000000e0
80000000 00000000 00000000 00000000
// flush drops pending ops, memory survives
00000000 00000000 00000006 00000000
90000300 00000000 00000000 00000000
13000303 00000000 5a5a1234 000000f0
80000000 00000000 00000000 00000000
20000311 00000024 00000000 00000000
13000323 00000000 ffffffff 000000f0
50000000 00000000 00000000 00000000
a0000000 00000000 00000001 00000000
30000240 00000000 000000f0 00000000
70000000 00000000 0000000a 00000000
90000330 00000000 5a5a1234 00000000
10000333 00000000 00000000 000000f0
80000000 00000000 00000000 00000000
f0000000 00000000 00000000 00000000

// File: dv/lsu_iq_tb.sv
`timescale 1ns/1ps

module lsu_iq_tb
    import lsu_iq_pkg::*;
();

    localparam real CLK_PERIOD     = 8.0;
    localparam int  RST_CYCLES     = 16;
    localparam int  STIM_WORDS     = 512;
    localparam int  CYCLES_PER_CMD = 20;
    localparam int  TIMEOUT_MARGIN = 200;

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    logic    [1:0]        disp_valid;
    lsu_op_e [1:0]        disp_op;
    imm_t    [1:0]        disp_imm;
    rob_id_t [1:0]        disp_dst;
    rob_id_t [1:0][1:0]   disp_src_tag;
    logic    [1:0][1:0]   disp_src_rdy;
    word_t   [1:0][1:0]   disp_src_data;
    logic                 disp_ready;
    logic                 cdb_valid;
    rob_id_t              cdb_tag;
    word_t                cdb_data;
    logic                 res_valid;
    logic                 res_ready;
    rob_id_t              res_tag;
    word_t                res_data;

    logic [31:0] stim [STIM_WORDS];
    integer      seed = 32'h2d193e44;
    rob_id_t     exp_tag_q  [$];
    word_t       exp_data_q [$];
    int          exp_sect_q [$];
    int          section     = 0;
    int          stall_left  = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;
    logic        pend_cdb    = 1'b0;

    lsu_iq_top DUT (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .flush_i         (flush),
        .disp_valid_i    (disp_valid),
        .disp_op_i       (disp_op),
        .disp_imm_i      (disp_imm),
        .disp_dst_i      (disp_dst),
        .disp_src_tag_i  (disp_src_tag),
        .disp_src_rdy_i  (disp_src_rdy),
        .disp_src_data_i (disp_src_data),
        .disp_ready_o    (disp_ready),
        .cdb_valid_i     (cdb_valid),
        .cdb_tag_i       (cdb_tag),
        .cdb_data_i      (cdb_data),
        .res_valid_o     (res_valid),
        .res_ready_i     (res_ready),
        .res_tag_o       (res_tag),
        .res_data_o      (res_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2.0) clk = ~clk;
    end

    // ----------------------------------------
    // reporting helpers
    // ----------------------------------------
    function automatic string section_name(int s);
        case (s)
            1:       return "store_load";
            2:       return "byte_ops";
            3:       return "wakeup";
            4:       return "order_full";
            5:       return "backpressure";
            6:       return "flush";
            default: return "startup";
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            abort_run($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic take_result();
        string name;
        if (exp_tag_q.size() == 0) begin
            abort_run($sformatf("result with tag %h arrived but no result was expected", res_tag));
        end else begin
            name = section_name(exp_sect_q.pop_front());
            check({name, " tag"}, 64'(exp_tag_q.pop_front()), 64'(res_tag));
            check({name, " data"}, 64'(exp_data_q.pop_front()), 64'(res_data));
        end
    endtask

    // ----------------------------------------
    // drivers
    // ----------------------------------------
    task automatic clear_dispatch();
        disp_valid = '0;
        for (int s = 0; s < 2; s++) begin
            disp_op[s]       = LD_W;
            disp_imm[s]      = '0;
            disp_dst[s]      = '0;
            disp_src_tag[s]  = '0;
            disp_src_rdy[s]  = '0;
            disp_src_data[s] = '0;
        end
    endtask

    // record word 0 holds op, imm, dst and ready bits, word 1 the source tags
    task automatic set_slot(input int s, input logic [31:0] c, input logic [31:0] t,
                            input logic [31:0] d0, input logic [31:0] d1);
        disp_op[s]                  = lsu_op_e'(c[26:24]);
        disp_imm[s]                 = c[23:12];
        disp_dst[s]                 = c[9:4];
        disp_src_rdy[s]             = c[1:0];
        disp_src_tag[s][OPND_DATA]  = t[13:8];
        disp_src_tag[s][OPND_BASE]  = t[5:0];
        disp_src_data[s][OPND_DATA] = d0;
        disp_src_data[s][OPND_BASE] = d1;
    endtask

    task automatic dispatch(input logic [1:0] slots);
        while (disp_ready !== 1'b1) begin
            @(negedge clk);
        end
        disp_valid = slots;
        // a queued broadcast goes out with this dispatch
        if (pend_cdb) begin
            cdb_valid = 1'b1;
        end
        @(negedge clk);
        clear_dispatch();
        cdb_valid = 1'b0;
        pend_cdb  = 1'b0;
    endtask

    task automatic broadcast(input rob_id_t tag, input word_t data);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_data  = data;
        @(negedge clk);
        cdb_valid = 1'b0;
    endtask

    // result port: ready pattern first, then the handshake of the coming edge
    always @(negedge clk) begin
        if (stall_left > 0) begin
            res_ready = 1'b0;
            stall_left--;
        end else begin
            res_ready = 1'b1;
        end
        if (res_valid === 1'b1 && res_ready) begin
            take_result();
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles", cycle_cnt));
        end
    end

    // ----------------------------------------
    // command sequencer
    // ----------------------------------------
    initial begin
        int          pc;
        int          n_cmds;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;

        rst_n     = 1'b0;
        flush     = 1'b0;
        cdb_valid = 1'b0;
        cdb_tag   = '0;
        cdb_data  = '0;
        res_ready = 1'b1;
        clear_dispatch();

        $readmemh("dv/lsu_iq_stimulus.txt", stim);
        n_cmds = 0;
        while (n_cmds * 4 < STIM_WORDS && stim[n_cmds * 4][31:28] !== 4'hf) begin
            n_cmds++;
        end
        if (n_cmds * 4 >= STIM_WORDS) begin
            abort_run("stimulus file has no end command");
        end
        cycle_limit = n_cmds * CYCLES_PER_CMD + TIMEOUT_MARGIN;

        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check("reset res_valid", 64'd0, 64'(res_valid));
        check("reset disp_ready", 64'd1, 64'(disp_ready));

        pc = 0;
        while (stim[pc * 4][31:28] !== 4'hf) begin
            w0 = stim[pc * 4];
            w1 = stim[pc * 4 + 1];
            w2 = stim[pc * 4 + 2];
            w3 = stim[pc * 4 + 3];
            case (w0[31:28])
                4'h0: section = int'(w2);
                4'h1: begin
                    set_slot(0, w0, w1, w2, w3);
                    dispatch(2'b01);
                end
                4'h2: begin
                    set_slot(0, w0, w1, w2, w3);
                    pc++;
                    set_slot(1, stim[pc * 4], stim[pc * 4 + 1], stim[pc * 4 + 2],
                             stim[pc * 4 + 3]);
                    dispatch(2'b11);
                end
                4'h3: broadcast(w0[9:4], w2);
                4'h4: begin
                    cdb_tag  = w0[9:4];
                    cdb_data = w2;
                    pend_cdb = 1'b1;
                end
                4'h5: begin
                    flush = 1'b1;
                    @(negedge clk);
                    flush = 1'b0;
                end
                4'h6: stall_left = stall_left + int'(w2) + int'($unsigned($random(seed)) % 8);
                4'h7: repeat (int'(w2)) @(negedge clk);
                4'h8: begin
                    while (exp_tag_q.size() != 0) begin
                        @(negedge clk);
                    end
                end
                4'h9: begin
                    exp_tag_q.push_back(w0[9:4]);
                    exp_data_q.push_back(w2);
                    exp_sect_q.push_back(section);
                end
                4'ha: check({section_name(section), " disp_ready"}, 64'(w2[0]), 64'(disp_ready));
                default: abort_run($sformatf("unknown command %h in stimulus file", w0[31:28]));
            endcase
            pc++;
        end

        // catch stray results after the last command
        repeat (10) @(negedge clk);
        if (exp_tag_q.size() != 0) begin
            abort_run($sformatf("%0d expected results never arrived", exp_tag_q.size()));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// File: sim.f
design/lsu_iq_pkg.sv
design/lsu_iq_ctrl.sv
design/iq_entry.sv
design/lsu_agu.sv
design/lsu_dmem.sv
design/lsu_iq_top.sv
dv/lsu_iq_properties.sv
dv/lsu_iq_tb.sv
